/* common/cu_pkg.sv */
package cu_pkg;

  // instruction set widths
  localparam int opcode_w  = 5;
  localparam int alu_src_w = 2;
  localparam int sel_w     = 2;

  // opcode encodings
  localparam logic [opcode_w-1:0] op_nop  = 5'b00000;
  localparam logic [opcode_w-1:0] op_out  = 5'b00110;
  localparam logic [opcode_w-1:0] op_push = 5'b00111;
  localparam logic [opcode_w-1:0] op_in   = 5'b01111;
  localparam logic [opcode_w-1:0] op_pop  = 5'b10000;
  localparam logic [opcode_w-1:0] op_ldm  = 5'b10001;
  localparam logic [opcode_w-1:0] op_ldd  = 5'b10010;
  localparam logic [opcode_w-1:0] op_std  = 5'b10011;
  localparam logic [opcode_w-1:0] op_call = 5'b11000;
  localparam logic [opcode_w-1:0] op_ret  = 5'b11001;
  localparam logic [opcode_w-1:0] op_rti  = 5'b11010;

  // register-writing alu ops in the low opcode space
  localparam logic [opcode_w-1:0] op_alu_lo = 5'b00011;
  localparam logic [opcode_w-1:0] op_alu_hi = 5'b00101;

  // alu forms that take the immediate operand
  localparam logic [opcode_w-1:0] op_imm_a = 5'b01101;
  localparam logic [opcode_w-1:0] op_imm_b = 5'b01110;

  // opcode prefixes: 01xxx writes a register, 101xx is a branch
  localparam logic [1:0] alu_prefix = 2'b01;
  localparam logic [2:0] br_prefix  = 3'b101;

  // memory write data select
  localparam logic [sel_w-1:0] mds_none = 2'b00;
  localparam logic [sel_w-1:0] mds_pc1  = 2'b01;
  localparam logic [sel_w-1:0] mds_pc2  = 2'b10;
  localparam logic [sel_w-1:0] mds_ccr  = 2'b11;

  // pc source select
  localparam logic [sel_w-1:0] pcs_next   = 2'b00;
  localparam logic [sel_w-1:0] pcs_vector = 2'b10;
  localparam logic [sel_w-1:0] pcs_target = 2'b11;

endpackage

/* source/opcode_decoder.sv */
`timescale 1ns/1ns

module opcode_decoder (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [cu_pkg::opcode_w-1:0]  opcode,
  output logic [cu_pkg::opcode_w-1:0]  alu_op,
  output logic [cu_pkg::alu_src_w-1:0] alu_src,
  output logic                         reg_wr,
  output logic                         mem_rd,
  output logic                         mem_wr,
  output logic                         mem_to_reg,
  output logic                         stack,
  output logic                         port_rd,
  output logic                         port_wr,
  output logic                         branch,
  output logic                         ldm,
  output logic                         ldm_value,
  output logic                         freeze_cu,
  output logic                         call_req,
  output logic                         ret_req,
  output logic                         rti_req
);
  import cu_pkg::*;

  logic [opcode_w-1:0] op;
  logic                is_alu;
  logic                is_ldm;

  // the word after ldm is immediate data, decode it as a nop
  assign op     = ldm_value ? op_nop : opcode;
  assign is_ldm = (op == op_ldm);

  // marks the immediate word of ldm
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ldm_value <= 1'b0;
    else
      ldm_value <= is_ldm;
  end

  assign is_alu = ((op >= op_alu_lo) && (op <= op_alu_hi)) || (op[4:3] == alu_prefix);

  assign alu_op  = op;
  assign alu_src = {is_ldm, (op == op_imm_a) || (op == op_imm_b)};

  assign reg_wr     = is_alu || (op == op_pop) || is_ldm || (op == op_ldd);
  assign mem_rd     = (op == op_pop) || (op == op_ldd);
  assign mem_wr     = (op == op_push) || (op == op_std);
  assign mem_to_reg = (op == op_pop) || (op == op_ldd);
  assign stack      = (op == op_pop) || (op == op_push);
  assign port_rd    = (op == op_in);
  assign port_wr    = (op == op_out);
  assign branch     = (op[4:2] == br_prefix);

  // decode holds while the immediate word is fetched
  assign ldm       = is_ldm;
  assign freeze_cu = is_ldm;

  // multi-cycle triggers, levels while the opcode sits in decode
  assign call_req = (op == op_call);
  assign ret_req  = (op == op_ret);
  assign rti_req  = (op == op_rti);

endmodule

/* sequencers/call_seq.sv */
`timescale 1ns/1ns

module call_seq (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     call_req,
  output logic                     mem_wr,
  output logic                     stack,
  output logic                     push_pc1,
  output logic                     push_pc2,
  output logic                     flush,
  output logic [cu_pkg::sel_w-1:0] pc_sel
);
  import cu_pkg::*;

  typedef enum logic {
    st_idle,
    st_push_hi
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    mem_wr     = 1'b0;
    stack      = 1'b0;
    push_pc1   = 1'b0;
    push_pc2   = 1'b0;
    flush      = 1'b0;
    pc_sel     = pcs_next;
    case (state)
      st_idle:
        // first half goes out while the target is taken
        if (call_req)
        begin
          mem_wr     = 1'b1;
          stack      = 1'b1;
          push_pc1   = 1'b1;
          pc_sel     = pcs_target;
          next_state = st_push_hi;
        end
      st_push_hi:
      begin
        mem_wr     = 1'b1;
        stack      = 1'b1;
        push_pc2   = 1'b1;
        // drop the instruction fetched behind the call
        flush      = 1'b1;
        next_state = st_idle;
      end
    endcase
  end

endmodule

/* sequencers/return_seq.sv */
`timescale 1ns/1ns

module return_seq (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ret_req,
  input  logic                     rti_req,
  output logic                     mem_rd,
  output logic                     stack,
  output logic                     pop_ccr,
  output logic                     pop_pc1,
  output logic                     pop_pc2,
  output logic                     freeze_pc,
  output logic                     freeze_cu,
  output logic                     flush,
  output logic [cu_pkg::sel_w-1:0] pc_sel
);
  import cu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_pop_ccr,
    st_pop_pc2,
    st_pop_pc1
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= next_state;
  end

  // the first pop state chosen at the trigger records rti vs ret
  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:
        if (rti_req)
          next_state = st_pop_ccr;
        else if (ret_req)
          next_state = st_pop_pc2;
      st_pop_ccr: next_state = st_pop_pc2;
      st_pop_pc2: next_state = st_pop_pc1;
      st_pop_pc1: next_state = st_idle;
    endcase
  end

  // every pop reads the stack with pc and decode held
  always_comb
  begin
    mem_rd    = (state != st_idle);
    stack     = (state != st_idle);
    freeze_pc = (state != st_idle);
    freeze_cu = (state != st_idle);
    pop_ccr   = (state == st_pop_ccr);
    pop_pc2   = (state == st_pop_pc2);
    pop_pc1   = (state == st_pop_pc1);
    // popped pc is complete on the last pop
    flush     = (state == st_pop_pc1);
    pc_sel    = (state == st_pop_pc1) ? pcs_target : pcs_next;
  end

endmodule

/* sequencers/interrupt_seq.sv */
`timescale 1ns/1ns

module interrupt_seq (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     interrupt,
  input  logic                     ldm,
  input  logic                     load_use,
  input  logic                     branch_taken,
  output logic                     ack,
  output logic                     mem_wr,
  output logic                     stack,
  output logic                     push_pc1,
  output logic                     push_pc2,
  output logic                     push_ccr,
  output logic                     freeze_pc,
  output logic                     freeze_cu,
  output logic [cu_pkg::sel_w-1:0] pc_sel
);
  import cu_pkg::*;

  typedef enum logic [3:0] {
    st_idle,
    st_ack,
    st_stall,
    st_frz_pc,
    st_frz_all,
    st_drain1,
    st_drain2,
    st_push_pc1,
    st_push_pc2,
    st_push_ccr
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = st_idle;
    ack        = 1'b0;
    mem_wr     = 1'b0;
    stack      = 1'b0;
    push_pc1   = 1'b0;
    push_pc2   = 1'b0;
    push_ccr   = 1'b0;
    freeze_pc  = 1'b0;
    freeze_cu  = 1'b0;
    pc_sel     = pcs_next;
    case (state)
      st_idle:
        if (interrupt)
          next_state = st_ack;
      st_ack:
      begin
        ack = 1'b1;
        // a pending ldm word or load-use stall needs one more cycle
        if (ldm || load_use)
          next_state = st_stall;
        else
        begin
          // let a taken branch redirect before the pc is held
          freeze_pc  = ~branch_taken;
          next_state = st_frz_pc;
        end
      end
      st_stall:
        next_state = st_frz_pc;
      st_frz_pc:
      begin
        freeze_pc  = 1'b1;
        next_state = st_frz_all;
      end
      st_frz_all:
      begin
        freeze_pc  = 1'b1;
        freeze_cu  = 1'b1;
        next_state = st_drain1;
      end
      st_drain1, st_drain2:
      begin
        freeze_pc  = 1'b1;
        freeze_cu  = 1'b1;
        next_state = (state == st_drain1) ? st_drain2 : st_push_pc1;
      end
      st_push_pc1, st_push_pc2:
      begin
        freeze_pc  = 1'b1;
        freeze_cu  = 1'b1;
        mem_wr     = 1'b1;
        stack      = 1'b1;
        push_pc1   = (state == st_push_pc1);
        push_pc2   = (state == st_push_pc2);
        next_state = (state == st_push_pc1) ? st_push_pc2 : st_push_ccr;
      end
      st_push_ccr:
      begin
        // pc is released here so the vector is loaded
        freeze_cu = 1'b1;
        mem_wr    = 1'b1;
        stack     = 1'b1;
        push_ccr  = 1'b1;
        pc_sel    = pcs_vector;
      end
      default:
        next_state = st_idle;
    endcase
  end

endmodule

/* source/control_merge.sv */
`timescale 1ns/1ns

module control_merge (
  input  logic                     dec_mem_rd,
  input  logic                     dec_mem_wr,
  input  logic                     dec_stack,
  input  logic                     dec_freeze_cu,
  input  logic                     call_mem_wr,
  input  logic                     call_stack,
  input  logic                     call_push_pc1,
  input  logic                     call_push_pc2,
  input  logic                     call_flush,
  input  logic [cu_pkg::sel_w-1:0] call_pc_sel,
  input  logic                     ret_mem_rd,
  input  logic                     ret_stack,
  input  logic                     ret_pop_ccr,
  input  logic                     ret_pop_pc1,
  input  logic                     ret_pop_pc2,
  input  logic                     ret_freeze_pc,
  input  logic                     ret_freeze_cu,
  input  logic                     ret_flush,
  input  logic [cu_pkg::sel_w-1:0] ret_pc_sel,
  input  logic                     int_mem_wr,
  input  logic                     int_stack,
  input  logic                     int_push_pc1,
  input  logic                     int_push_pc2,
  input  logic                     int_push_ccr,
  input  logic                     int_freeze_pc,
  input  logic                     int_freeze_cu,
  input  logic [cu_pkg::sel_w-1:0] int_pc_sel,
  input  logic                     branch_taken,
  output logic                     mem_rd,
  output logic                     mem_wr,
  output logic                     stack,
  output logic [cu_pkg::sel_w-1:0] mem_data_sel,
  output logic [cu_pkg::sel_w-1:0] pc_sel,
  output logic                     pop_ccr,
  output logic                     pop_pc1,
  output logic                     pop_pc2,
  output logic                     freeze_cu,
  output logic                     fetch_pc_enable,
  output logic                     flush_fetch,
  output logic                     flush_decode
);
  import cu_pkg::*;

  logic freeze_pc;

  assign mem_rd    = dec_mem_rd | ret_mem_rd;
  assign mem_wr    = dec_mem_wr | call_mem_wr | int_mem_wr;
  assign stack     = dec_stack | call_stack | ret_stack | int_stack;
  assign freeze_cu = dec_freeze_cu | ret_freeze_cu | int_freeze_cu;
  assign freeze_pc = ret_freeze_pc | int_freeze_pc;

  // pc1 wins over pc2, ccr last
  always_comb
  begin
    if (call_push_pc1 || int_push_pc1)
      mem_data_sel = mds_pc1;
    else if (call_push_pc2 || int_push_pc2)
      mem_data_sel = mds_pc2;
    else if (int_push_ccr)
      mem_data_sel = mds_ccr;
    else
      mem_data_sel = mds_none;
  end

  assign pc_sel = branch_taken ? pcs_target : (call_pc_sel | ret_pc_sel | int_pc_sel);

  assign pop_ccr = ret_pop_ccr;
  assign pop_pc1 = ret_pop_pc1;
  assign pop_pc2 = ret_pop_pc2;

  assign fetch_pc_enable = ~freeze_pc;
  assign flush_fetch     = branch_taken | call_flush;
  assign flush_decode    = ret_flush;

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [cu_pkg::opcode_w-1:0]  opcode,
  input  logic                         interrupt,
  input  logic                         load_use,
  input  logic                         branch_taken,
  output logic                         ack,
  output logic [cu_pkg::opcode_w-1:0]  alu_op,
  output logic [cu_pkg::alu_src_w-1:0] alu_src,
  output logic                         reg_wr,
  output logic                         mem_to_reg,
  output logic                         port_rd,
  output logic                         port_wr,
  output logic                         branch,
  output logic                         ldm_value,
  output logic                         call,
  output logic                         ret,
  output logic                         rti,
  output logic                         mem_rd,
  output logic                         mem_wr,
  output logic                         stack,
  output logic [cu_pkg::sel_w-1:0]     mem_data_sel,
  output logic [cu_pkg::sel_w-1:0]     pc_sel,
  output logic                         pop_ccr,
  output logic                         pop_pc1,
  output logic                         pop_pc2,
  output logic                         freeze_cu,
  output logic                         fetch_pc_enable,
  output logic                         flush_fetch,
  output logic                         flush_decode
);
  import cu_pkg::*;

  logic             dec_mem_rd, dec_mem_wr, dec_stack, dec_freeze_cu, dec_ldm;
  logic             call_mem_wr, call_stack, call_push_pc1, call_push_pc2, call_flush;
  logic             ret_mem_rd, ret_stack, ret_pop_ccr, ret_pop_pc1, ret_pop_pc2;
  logic             ret_freeze_pc, ret_freeze_cu, ret_flush;
  logic             int_mem_wr, int_stack, int_push_pc1, int_push_pc2, int_push_ccr;
  logic             int_freeze_pc, int_freeze_cu;
  logic [sel_w-1:0] call_pc_sel, ret_pc_sel, int_pc_sel;

  opcode_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .opcode     (opcode),
    .alu_op     (alu_op),
    .alu_src    (alu_src),
    .reg_wr     (reg_wr),
    .mem_rd     (dec_mem_rd),
    .mem_wr     (dec_mem_wr),
    .mem_to_reg (mem_to_reg),
    .stack      (dec_stack),
    .port_rd    (port_rd),
    .port_wr    (port_wr),
    .branch     (branch),
    .ldm        (dec_ldm),
    .ldm_value  (ldm_value),
    .freeze_cu  (dec_freeze_cu),
    .call_req   (call),
    .ret_req    (ret),
    .rti_req    (rti)
  );

  call_seq u_call (
    .clk      (clk),
    .rst      (rst),
    .call_req (call),
    .mem_wr   (call_mem_wr),
    .stack    (call_stack),
    .push_pc1 (call_push_pc1),
    .push_pc2 (call_push_pc2),
    .flush    (call_flush),
    .pc_sel   (call_pc_sel)
  );

  return_seq u_return (
    .clk       (clk),
    .rst       (rst),
    .ret_req   (ret),
    .rti_req   (rti),
    .mem_rd    (ret_mem_rd),
    .stack     (ret_stack),
    .pop_ccr   (ret_pop_ccr),
    .pop_pc1   (ret_pop_pc1),
    .pop_pc2   (ret_pop_pc2),
    .freeze_pc (ret_freeze_pc),
    .freeze_cu (ret_freeze_cu),
    .flush     (ret_flush),
    .pc_sel    (ret_pc_sel)
  );

  interrupt_seq u_interrupt (
    .clk          (clk),
    .rst          (rst),
    .interrupt    (interrupt),
    .ldm          (dec_ldm),
    .load_use     (load_use),
    .branch_taken (branch_taken),
    .ack          (ack),
    .mem_wr       (int_mem_wr),
    .stack        (int_stack),
    .push_pc1     (int_push_pc1),
    .push_pc2     (int_push_pc2),
    .push_ccr     (int_push_ccr),
    .freeze_pc    (int_freeze_pc),
    .freeze_cu    (int_freeze_cu),
    .pc_sel       (int_pc_sel)
  );

  control_merge u_merge (
    .dec_mem_rd      (dec_mem_rd),
    .dec_mem_wr      (dec_mem_wr),
    .dec_stack       (dec_stack),
    .dec_freeze_cu   (dec_freeze_cu),
    .call_mem_wr     (call_mem_wr),
    .call_stack      (call_stack),
    .call_push_pc1   (call_push_pc1),
    .call_push_pc2   (call_push_pc2),
    .call_flush      (call_flush),
    .call_pc_sel     (call_pc_sel),
    .ret_mem_rd      (ret_mem_rd),
    .ret_stack       (ret_stack),
    .ret_pop_ccr     (ret_pop_ccr),
    .ret_pop_pc1     (ret_pop_pc1),
    .ret_pop_pc2     (ret_pop_pc2),
    .ret_freeze_pc   (ret_freeze_pc),
    .ret_freeze_cu   (ret_freeze_cu),
    .ret_flush       (ret_flush),
    .ret_pc_sel      (ret_pc_sel),
    .int_mem_wr      (int_mem_wr),
    .int_stack       (int_stack),
    .int_push_pc1    (int_push_pc1),
    .int_push_pc2    (int_push_pc2),
    .int_push_ccr    (int_push_ccr),
    .int_freeze_pc   (int_freeze_pc),
    .int_freeze_cu   (int_freeze_cu),
    .int_pc_sel      (int_pc_sel),
    .branch_taken    (branch_taken),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .stack           (stack),
    .mem_data_sel    (mem_data_sel),
    .pc_sel          (pc_sel),
    .pop_ccr         (pop_ccr),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .freeze_cu       (freeze_cu),
    .fetch_pc_enable (fetch_pc_enable),
    .flush_fetch     (flush_fetch),
    .flush_decode    (flush_decode)
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  // 4 ns period
  localparam int half_period = 2;

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

/* sim/tb_control_unit.sv */
`timescale 1ns/1ns

module tb_control_unit;
  import cu_pkg::*;

  localparam int n_cols       = 11;
  localparam int n_patterns   = 48;
  localparam int reset_cycles = 8;
  localparam int max_gap      = 3;
  localparam int period_ns    = 4;
  // every pattern may carry a full gap, plus reset and some slack
  localparam int watchdog_ns  = (reset_cycles + n_patterns * (max_gap + 1) + 20) * period_ns;

  logic                   clk;
  logic                   rst;
  logic [opcode_w-1:0]    opcode;
  logic                   interrupt;
  logic                   load_use;
  logic                   branch_taken;
  logic                   ack;
  logic [opcode_w-1:0]    alu_op;
  logic [alu_src_w-1:0]   alu_src;
  logic                   reg_wr;
  logic                   mem_to_reg;
  logic                   port_rd;
  logic                   port_wr;
  logic                   branch;
  logic                   ldm_value;
  logic                   call;
  logic                   ret;
  logic                   rti;
  logic                   mem_rd;
  logic                   mem_wr;
  logic                   stack;
  logic [sel_w-1:0]       mem_data_sel;
  logic [sel_w-1:0]       pc_sel;
  logic                   pop_ccr;
  logic                   pop_pc1;
  logic                   pop_pc2;
  logic                   freeze_cu;
  logic                   fetch_pc_enable;
  logic                   flush_fetch;
  logic                   flush_decode;

  // one row per cycle: two stimulus columns, then nine expected columns
  logic [7:0] patterns [0:n_patterns*n_cols-1];
  logic [7:0] expected [0:n_cols-3];
  int         errors;
  int         checks;
  integer     seed = 32'h83c5;

  tb_clock i_clock (
    .clk (clk)
  );

  control_unit i_dut (
    .clk             (clk),
    .rst             (rst),
    .opcode          (opcode),
    .interrupt       (interrupt),
    .load_use        (load_use),
    .branch_taken    (branch_taken),
    .ack             (ack),
    .alu_op          (alu_op),
    .alu_src         (alu_src),
    .reg_wr          (reg_wr),
    .mem_to_reg      (mem_to_reg),
    .port_rd         (port_rd),
    .port_wr         (port_wr),
    .branch          (branch),
    .ldm_value       (ldm_value),
    .call            (call),
    .ret             (ret),
    .rti             (rti),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .stack           (stack),
    .mem_data_sel    (mem_data_sel),
    .pc_sel          (pc_sel),
    .pop_ccr         (pop_ccr),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .freeze_cu       (freeze_cu),
    .fetch_pc_enable (fetch_pc_enable),
    .flush_fetch     (flush_fetch),
    .flush_decode    (flush_decode)
  );

  task automatic check_bit(input string name, input logic actual, input logic exp_val);
    checks++;
    assert (actual === exp_val)
    else
    begin
      errors++;
      $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, exp_val, actual);
    end
  endtask

  task automatic check_field(input string name, input logic [7:0] actual,
                             input logic [7:0] exp_val);
    checks++;
    assert (actual === exp_val)
    else
    begin
      errors++;
      $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, exp_val, actual);
    end
  endtask

  task automatic check_outputs();
    check_field("alu_op", 8'(alu_op), expected[0]);
    check_field("alu_src", 8'(alu_src), expected[1]);
    check_bit("reg_wr", reg_wr, expected[2][5]);
    check_bit("mem_to_reg", mem_to_reg, expected[2][4]);
    check_bit("port_rd", port_rd, expected[2][3]);
    check_bit("port_wr", port_wr, expected[2][2]);
    check_bit("branch", branch, expected[2][1]);
    check_bit("ldm_value", ldm_value, expected[2][0]);
    check_bit("call", call, expected[3][3]);
    check_bit("ret", ret, expected[3][2]);
    check_bit("rti", rti, expected[3][1]);
    check_bit("ack", ack, expected[3][0]);
    check_bit("mem_rd", mem_rd, expected[4][2]);
    check_bit("mem_wr", mem_wr, expected[4][1]);
    check_bit("stack", stack, expected[4][0]);
    check_field("mem_data_sel", 8'(mem_data_sel), expected[5]);
    check_field("pc_sel", 8'(pc_sel), expected[6]);
    check_bit("pop_ccr", pop_ccr, expected[7][2]);
    check_bit("pop_pc2", pop_pc2, expected[7][1]);
    check_bit("pop_pc1", pop_pc1, expected[7][0]);
    check_bit("freeze_cu", freeze_cu, expected[8][3]);
    check_bit("fetch_pc_enable", fetch_pc_enable, expected[8][2]);
    check_bit("flush_fetch", flush_fetch, expected[8][1]);
    check_bit("flush_decode", flush_decode, expected[8][0]);
  endtask

  // drive on the falling edge, sample 1 ns before the rising edge
  task automatic apply_cycle(input logic [7:0] op, input logic [3:0] inputs);
    @(negedge clk);
    opcode       = op[opcode_w-1:0];
    interrupt    = inputs[2];
    load_use     = inputs[1];
    branch_taken = inputs[0];
    #1;
    check_outputs();
  endtask

  // nop cycles between groups, everything idle and the pc running
  task automatic idle_gap(input int cycles);
    for (int c = 0; c < n_cols - 2; c++)
      expected[c] = 8'h00;
    expected[8] = 8'b0100;
    repeat (cycles) apply_cycle(op_nop, 4'b0000);
  endtask

  initial
  begin
    int gap;
    int base;
    errors       = 0;
    checks       = 0;
    rst          = 1'b1;
    opcode       = op_nop;
    interrupt    = 1'b0;
    load_use     = 1'b0;
    branch_taken = 1'b0;
    $readmemb("sim/control_patterns.txt", patterns);
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < n_patterns; p++)
    begin
      base = p * n_cols;
      // top bit of the input column allows a random nop gap before this row
      if (patterns[base + 1][3])
      begin
        gap = $unsigned($random(seed)) % (max_gap + 1);
        idle_gap(gap);
      end
      for (int c = 0; c < n_cols - 2; c++)
        expected[c] = patterns[base + 2 + c];
      apply_cycle(patterns[base], patterns[base + 1][3:0]);
    end
    @(negedge clk);
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the pattern run did not finish within %0d ns", watchdog_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sim/control_patterns.txt */
// opcode {gap,interrupt,load_use,branch_taken} alu_op alu_src
// {reg_wr,mem_to_reg,port_rd,port_wr,branch,ldm_value} {call,ret,rti,ack}
// {mem_rd,mem_wr,stack} mem_data_sel pc_sel {pop_ccr,pop_pc2,pop_pc1}
// {freeze_cu,fetch_pc_enable,flush_fetch,flush_decode}
// single-cycle classes and branch_taken
00000 1000 00000 00 000000 0000 000 00 00 000 0100
00011 1000 00011 00 100000 0000 000 00 00 000 0100
01101 0000 01101 01 100000 0000 000 00 00 000 0100
00110 0000 00110 00 000100 0000 000 00 00 000 0100
01111 0000 01111 00 101000 0000 000 00 00 000 0100
00111 0000 00111 00 000000 0000 011 00 00 000 0100
10000 0000 10000 00 110000 0000 101 00 00 000 0100
10010 0000 10010 00 110000 0000 100 00 00 000 0100
10011 0000 10011 00 000000 0000 010 00 00 000 0100
10100 0000 10100 00 000010 0000 000 00 00 000 0100
10110 0001 10110 00 000010 0000 000 00 11 000 0110
00000 1001 00000 00 000000 0000 000 00 11 000 0110
// ldm then its immediate word
10001 1000 10001 10 100000 0000 000 00 00 000 1100
00000 0000 00000 00 000001 0000 000 00 00 000 0100
00000 0000 00000 00 000000 0000 000 00 00 000 0100
// call
11000 1000 11000 00 000000 1000 011 01 11 000 0100
00000 0000 00000 00 000000 0000 011 10 00 000 0110
00000 0000 00000 00 000000 0000 000 00 00 000 0100
// rti then ret
11010 1000 11010 00 000000 0010 000 00 00 000 0100
00000 0000 00000 00 000000 0000 101 00 00 100 1000
00000 0000 00000 00 000000 0000 101 00 00 010 1000
00000 0000 00000 00 000000 0000 101 00 11 001 1001
00000 0000 00000 00 000000 0000 000 00 00 000 0100
11001 1000 11001 00 000000 0100 000 00 00 000 0100
00000 0000 00000 00 000000 0000 101 00 00 010 1000
00000 0000 00000 00 000000 0000 101 00 11 001 1001
00000 0000 00000 00 000000 0000 000 00 00 000 0100
// interrupt without a stall
00000 1100 00000 00 000000 0000 000 00 00 000 0100
00000 0000 00000 00 000000 0001 000 00 00 000 0000
00000 0000 00000 00 000000 0000 000 00 00 000 0000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 011 01 00 000 1000
00000 0000 00000 00 000000 0000 011 10 00 000 1000
00000 0000 00000 00 000000 0000 011 11 10 000 1100
00000 0000 00000 00 000000 0000 000 00 00 000 0100
// interrupt with load_use in the ack cycle
00000 1100 00000 00 000000 0000 000 00 00 000 0100
00000 0010 00000 00 000000 0001 000 00 00 000 0100
00000 0000 00000 00 000000 0000 000 00 00 000 0100
00000 0000 00000 00 000000 0000 000 00 00 000 0000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 000 00 00 000 1000
00000 0000 00000 00 000000 0000 011 01 00 000 1000
00000 0000 00000 00 000000 0000 011 10 00 000 1000
00000 0000 00000 00 000000 0000 011 11 10 000 1100
00000 0000 00000 00 000000 0000 000 00 00 000 0100

/* src.f */
common/cu_pkg.sv
source/opcode_decoder.sv
sequencers/call_seq.sv
sequencers/return_seq.sv
sequencers/interrupt_seq.sv
source/control_merge.sv
source/control_unit.sv
sim/tb_clock.sv
sim/tb_control_unit.sv

/* Makefile */
# Verilator build and run for the control unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_control_unit
RTL_TOP    ?= control_unit
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TESTBENCH PASSED
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
